/* Bender.yml */
package:
  name: noc_endpoint_loopback

sources:
  - files:
      - rtl/noc_pkg.sv
      - rtl/noc_packet_packer.sv
      - rtl/noc_flit_fifo.sv
      - rtl/noc_packet_unpacker.sv
      - rtl/noc_endpoint_loopback.sv
  - target: test
    files:
      - test/noc_loopback_tb.sv

/* compile.f */
rtl/noc_pkg.sv
rtl/noc_packet_packer.sv
rtl/noc_flit_fifo.sv
rtl/noc_packet_unpacker.sv
rtl/noc_endpoint_loopback.sv
test/noc_loopback_tb.sv

/* rtl/noc_endpoint_loopback.sv */
`timescale 1ns/1ps

module noc_endpoint_loopback (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_header_valid,
  output logic                               in_header_ready,
  input  noc_pkg::noc_packet_type_e          in_packet_type,
  input  logic [noc_pkg::ID_WIDTH-1:0]       in_destination_id,
  input  logic [noc_pkg::ID_WIDTH-1:0]       in_source_id,
  input  logic [noc_pkg::TAG_WIDTH-1:0]      in_tag,
  input  logic [noc_pkg::BURST_WIDTH-1:0]    in_burst_length,
  input  logic [noc_pkg::ADDR_WIDTH-1:0]     in_address,
  input  noc_pkg::noc_status_e               in_header_status,
  input  logic                               in_payload_valid,
  output logic                               in_payload_ready,
  input  logic [noc_pkg::DATA_WIDTH-1:0]     in_data,
  input  logic [noc_pkg::BE_WIDTH-1:0]       in_byte_enable,
  input  noc_pkg::noc_status_e               in_payload_status,
  input  logic                               in_payload_last,
  output logic                               out_header_valid,
  input  logic                               out_header_ready,
  output noc_pkg::noc_packet_type_e          out_packet_type,
  output logic [noc_pkg::ID_WIDTH-1:0]       out_destination_id,
  output logic [noc_pkg::ID_WIDTH-1:0]       out_source_id,
  output logic [noc_pkg::TAG_WIDTH-1:0]      out_tag,
  output logic [noc_pkg::BURST_WIDTH-1:0]    out_burst_length,
  output logic [noc_pkg::ADDR_WIDTH-1:0]     out_address,
  output noc_pkg::noc_status_e               out_header_status,
  output logic                               out_payload_valid,
  input  logic                               out_payload_ready,
  output logic [noc_pkg::DATA_WIDTH-1:0]     out_data,
  output logic [noc_pkg::BE_WIDTH-1:0]       out_byte_enable,
  output noc_pkg::noc_status_e               out_payload_status,
  output logic                               out_payload_last
);

  logic               tx_flit_valid;
  logic               tx_flit_ready;
  noc_pkg::noc_flit_s tx_flit;
  logic               rx_flit_valid;  // Link buffer toward the far endpoint
  logic               rx_flit_ready;
  noc_pkg::noc_flit_s rx_flit;

  noc_packet_packer u_packer (
    .clk            (clk),
    .rst_n          (rst_n),
    .header_valid   (in_header_valid),
    .header_ready   (in_header_ready),
    .packet_type    (in_packet_type),
    .destination_id (in_destination_id),
    .source_id      (in_source_id),
    .tag            (in_tag),
    .burst_length   (in_burst_length),
    .address        (in_address),
    .header_status  (in_header_status),
    .payload_valid  (in_payload_valid),
    .payload_ready  (in_payload_ready),
    .data           (in_data),
    .byte_enable    (in_byte_enable),
    .payload_status (in_payload_status),
    .payload_last   (in_payload_last),
    .flit_valid     (tx_flit_valid),
    .flit_ready     (tx_flit_ready),
    .flit           (tx_flit)
  );

  noc_flit_fifo #(
    .DEPTH (noc_pkg::FIFO_DEPTH)
  ) u_link_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (tx_flit_valid),
    .in_ready  (tx_flit_ready),
    .in_flit   (tx_flit),
    .out_valid (rx_flit_valid),
    .out_ready (rx_flit_ready),
    .out_flit  (rx_flit)
  );

  noc_packet_unpacker u_unpacker (
    .clk            (clk),
    .rst_n          (rst_n),
    .flit_valid     (rx_flit_valid),
    .flit_ready     (rx_flit_ready),
    .flit           (rx_flit),
    .header_valid   (out_header_valid),
    .header_ready   (out_header_ready),
    .packet_type    (out_packet_type),
    .destination_id (out_destination_id),
    .source_id      (out_source_id),
    .tag            (out_tag),
    .burst_length   (out_burst_length),
    .address        (out_address),
    .header_status  (out_header_status),
    .payload_valid  (out_payload_valid),
    .payload_ready  (out_payload_ready),
    .data           (out_data),
    .byte_enable    (out_byte_enable),
    .payload_status (out_payload_status),
    .payload_last   (out_payload_last)
  );

endmodule

/* rtl/noc_flit_fifo.sv */
`timescale 1ns/1ps

module noc_flit_fifo #(
  parameter int DEPTH = noc_pkg::FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  noc_pkg::noc_flit_s in_flit,
  output logic               out_valid,
  input  logic               out_ready,
  output noc_pkg::noc_flit_s out_flit
);

  noc_pkg::noc_flit_s         buffer [DEPTH];
  logic [$clog2(DEPTH)-1:0]   write_ptr;
  logic [$clog2(DEPTH)-1:0]   read_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  assign in_ready  = count != ($clog2(DEPTH+1))'(DEPTH);
  assign out_valid = count != '0;
  assign out_flit  = buffer[read_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      buffer[write_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (push) begin
        write_ptr <= (write_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
      end
      if (pop) begin
        read_ptr <= (read_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Equal pointers mean empty or full, and the count must say which
  no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (write_ptr != read_ptr) || (count == '0))
    else $error("Flit written into a full link buffer");

  no_underflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (write_ptr != read_ptr) || (count == ($clog2(DEPTH+1))'(DEPTH)))
    else $error("Flit read from an empty link buffer");

endmodule

/* rtl/noc_packet_packer.sv */
`timescale 1ns/1ps

module noc_packet_packer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               header_valid,
  output logic                               header_ready,
  input  noc_pkg::noc_packet_type_e          packet_type,
  input  logic [noc_pkg::ID_WIDTH-1:0]       destination_id,
  input  logic [noc_pkg::ID_WIDTH-1:0]       source_id,
  input  logic [noc_pkg::TAG_WIDTH-1:0]      tag,
  input  logic [noc_pkg::BURST_WIDTH-1:0]    burst_length,
  input  logic [noc_pkg::ADDR_WIDTH-1:0]     address,
  input  noc_pkg::noc_status_e               header_status,
  input  logic                               payload_valid,
  output logic                               payload_ready,
  input  logic [noc_pkg::DATA_WIDTH-1:0]     data,
  input  logic [noc_pkg::BE_WIDTH-1:0]       byte_enable,
  input  noc_pkg::noc_status_e               payload_status,
  input  logic                               payload_last,
  output logic                               flit_valid,
  input  logic                               flit_ready,
  output noc_pkg::noc_flit_s                 flit
);

  logic                    payload_phase;  // Low while header flits are sent
  logic                    header_index;
  logic                    header_last;
  logic                    no_payload;
  logic                    write_packet;
  logic                    flit_ack;
  noc_pkg::noc_flit_data_u header_word;
  noc_pkg::noc_flit_data_u payload_word;

  assign no_payload  = !noc_pkg::noc_has_payload(packet_type);
  assign header_last = {1'b0, header_index} == noc_pkg::noc_header_flits(packet_type) - 2'd1;

  assign flit_valid    = payload_phase ? payload_valid : header_valid;
  assign flit_ack      = flit_valid && flit_ready;
  // The header is only released once its last word has gone out
  assign header_ready  = !payload_phase && flit_ready && header_last;
  assign payload_ready = payload_phase && flit_ready;

  always_comb begin
    header_word = '0;
    if (header_index) begin
      header_word.header1.address = address;
    end else begin
      header_word.header0.packet_type    = packet_type;
      header_word.header0.destination_id = destination_id;
      header_word.header0.source_id      = source_id;
      header_word.header0.tag            = tag;
      header_word.header0.status         = header_status;
      header_word.header0.burst_length   = burst_length;
    end
  end

  always_comb begin
    payload_word = '0;
    if (write_packet) begin
      payload_word.write_payload.data        = data;
      payload_word.write_payload.byte_enable = byte_enable;
    end else begin
      payload_word.read_payload.data   = data;
      payload_word.read_payload.status = payload_status;
    end
  end

  always_comb begin
    if (payload_phase) begin
      flit.flit_type = noc_pkg::payload_flit;
      flit.head      = 1'b0;
      flit.tail      = payload_last;
      flit.data      = payload_word;
    end else begin
      flit.flit_type = noc_pkg::header_flit;
      flit.head      = !header_index;
      flit.tail      = no_payload && header_last;  // Closes a packet with no payload
      flit.data      = header_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      payload_phase <= 1'b0;
      header_index  <= 1'b0;
      write_packet  <= 1'b0;
    end else if (flit_ack) begin
      if (payload_phase) begin
        if (payload_last) begin
          payload_phase <= 1'b0;
        end
      end else if (header_last) begin
        header_index  <= 1'b0;
        payload_phase <= !no_payload;
        // Header fields may change once released, so keep the payload kind
        write_packet  <= packet_type == noc_pkg::write_request;
      end else begin
        header_index <= 1'b1;
      end
    end
  end

  flit_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    flit_valid && !flit_ready |=> flit_valid && $stable(flit))
    else $error("Flit changed while stalled by the link");

endmodule

/* rtl/noc_packet_unpacker.sv */
`timescale 1ns/1ps

module noc_packet_unpacker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flit_valid,
  output logic                               flit_ready,
  input  noc_pkg::noc_flit_s                 flit,
  output logic                               header_valid,
  input  logic                               header_ready,
  output noc_pkg::noc_packet_type_e          packet_type,
  output logic [noc_pkg::ID_WIDTH-1:0]       destination_id,
  output logic [noc_pkg::ID_WIDTH-1:0]       source_id,
  output logic [noc_pkg::TAG_WIDTH-1:0]      tag,
  output logic [noc_pkg::BURST_WIDTH-1:0]    burst_length,
  output logic [noc_pkg::ADDR_WIDTH-1:0]     address,
  output noc_pkg::noc_status_e               header_status,
  output logic                               payload_valid,
  input  logic                               payload_ready,
  output logic [noc_pkg::DATA_WIDTH-1:0]     data,
  output logic [noc_pkg::BE_WIDTH-1:0]       byte_enable,
  output noc_pkg::noc_status_e               payload_status,
  output logic                               payload_last
);

  noc_pkg::noc_header0_s     header0_reg;
  noc_pkg::noc_header1_s     header1_reg;
  noc_pkg::noc_packet_type_e incoming_type;
  logic                      header_index;
  logic                      header_tail;   // Tail seen on the last header flit
  logic                      payload_phase;
  logic                      collecting;
  logic                      header_done;

  assign collecting = !header_valid && !payload_phase;
  assign flit_ready = collecting || (payload_phase && payload_ready);

  // The first word names the packet type, later words rely on the stored one
  assign incoming_type = header_index ? header0_reg.packet_type : flit.data.header0.packet_type;
  assign header_done   = ({1'b0, header_index} == noc_pkg::noc_header_flits(incoming_type) - 2'd1)
                         || (flit.head && flit.tail);

  always_ff @(posedge clk) begin
    if (flit_valid && collecting) begin
      if (!header_index) begin
        header0_reg <= flit.data.header0;
        header1_reg <= '0;  // Responses carry no address
      end else begin
        header1_reg <= flit.data.header1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      header_valid  <= 1'b0;
      header_index  <= 1'b0;
      header_tail   <= 1'b0;
      payload_phase <= 1'b0;
    end else if (flit_valid && collecting) begin
      if (header_done) begin
        header_valid <= 1'b1;
        header_index <= 1'b0;
        header_tail  <= flit.tail;
      end else begin
        header_index <= 1'b1;
      end
    end else if (header_valid && header_ready) begin
      header_valid  <= 1'b0;
      payload_phase <= !header_tail;
    end else if (flit_valid && flit_ready && flit.tail) begin
      payload_phase <= 1'b0;
    end
  end

  assign packet_type    = header0_reg.packet_type;
  assign destination_id = header0_reg.destination_id;
  assign source_id      = header0_reg.source_id;
  assign tag            = header0_reg.tag;
  assign burst_length   = header0_reg.burst_length;
  assign header_status  = header0_reg.status;
  assign address        = header1_reg.address;

  assign payload_valid = payload_phase && flit_valid;
  assign payload_last  = flit.tail;

  assign data = flit.data.write_payload.data;  // Both payload kinds keep data in the low bits

  always_comb begin
    if (header0_reg.packet_type == noc_pkg::write_request) begin
      byte_enable    = flit.data.write_payload.byte_enable;
      payload_status = noc_pkg::okay;
    end else begin
      byte_enable    = '0;
      payload_status = flit.data.read_payload.status;
    end
  end

  header_first_a: assert property (@(posedge clk) disable iff (!rst_n)
    flit_valid && collecting |-> flit.flit_type == noc_pkg::header_flit)
    else $error("Payload flit arrived before its packet header");

endmodule

/* rtl/noc_pkg.sv */
package noc_pkg;

  localparam int FLIT_DATA_WIDTH       = 36;
  localparam int DATA_WIDTH            = 32;
  localparam int BE_WIDTH              = 4;
  localparam int ID_WIDTH              = 4;
  localparam int TAG_WIDTH             = 4;
  localparam int ADDR_WIDTH            = 32;
  localparam int BURST_WIDTH           = 8;  // Zero encodes a single beat
  localparam int FIFO_DEPTH            = 4;
  localparam int REQUEST_HEADER_FLITS  = 2;
  localparam int RESPONSE_HEADER_FLITS = 1;

  // Unused upper bits that fill each word out to a full flit
  localparam int HEADER0_PAD_WIDTH =
    FLIT_DATA_WIDTH - 3 - 2 * ID_WIDTH - TAG_WIDTH - 2 - BURST_WIDTH;
  localparam int HEADER1_PAD_WIDTH = FLIT_DATA_WIDTH - ADDR_WIDTH;
  localparam int READ_PAD_WIDTH    = FLIT_DATA_WIDTH - DATA_WIDTH - 2;

  typedef enum logic [2:0] {
    read_request   = 3'b000,
    write_request  = 3'b001,
    read_response  = 3'b100,
    write_response = 3'b101
  } noc_packet_type_e;

  typedef enum logic {
    header_flit  = 1'b0,
    payload_flit = 1'b1
  } noc_flit_type_e;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } noc_status_e;

  typedef struct packed {
    logic [HEADER0_PAD_WIDTH-1:0] reserved;
    noc_packet_type_e             packet_type;
    logic [ID_WIDTH-1:0]          destination_id;
    logic [ID_WIDTH-1:0]          source_id;
    logic [TAG_WIDTH-1:0]         tag;
    noc_status_e                  status;
    logic [BURST_WIDTH-1:0]       burst_length;
  } noc_header0_s;

  typedef struct packed {
    logic [HEADER1_PAD_WIDTH-1:0] reserved;
    logic [ADDR_WIDTH-1:0]        address;
  } noc_header1_s;

  typedef struct packed {
    logic [BE_WIDTH-1:0]   byte_enable;
    logic [DATA_WIDTH-1:0] data;
  } noc_write_payload_s;

  typedef struct packed {
    logic [READ_PAD_WIDTH-1:0] reserved;
    noc_status_e               status;
    logic [DATA_WIDTH-1:0]     data;
  } noc_read_payload_s;

  // One flit word, read by its position in the packet and the packet type
  typedef union packed {
    noc_header0_s       header0;
    noc_header1_s       header1;
    noc_write_payload_s write_payload;
    noc_read_payload_s  read_payload;
  } noc_flit_data_u;

  typedef struct packed {
    noc_flit_type_e flit_type;
    logic           head;
    logic           tail;
    noc_flit_data_u data;
  } noc_flit_s;

  function automatic logic noc_is_request(noc_packet_type_e packet_type);
    return (packet_type == read_request) || (packet_type == write_request);
  endfunction

  function automatic logic noc_has_payload(noc_packet_type_e packet_type);
    return (packet_type == write_request) || (packet_type == read_response);
  endfunction

  function automatic logic [1:0] noc_header_flits(noc_packet_type_e packet_type);
    return noc_is_request(packet_type) ? 2'(REQUEST_HEADER_FLITS) : 2'(RESPONSE_HEADER_FLITS);
  endfunction

endpackage

/* test/noc_loopback_tb.sv */
`timescale 1ns/1ps

module noc_loopback_tb;

  localparam int NUM_PACKETS     = 14;
  localparam int MAX_BEATS       = 8;
  localparam int WATCHDOG_CYCLES = NUM_PACKETS * (MAX_BEATS + 4) * 4;

  logic                              clk;
  logic                              rst_n;
  logic                              in_header_valid;
  logic                              in_header_ready;
  noc_pkg::noc_packet_type_e         in_packet_type;
  logic [noc_pkg::ID_WIDTH-1:0]      in_destination_id;
  logic [noc_pkg::ID_WIDTH-1:0]      in_source_id;
  logic [noc_pkg::TAG_WIDTH-1:0]     in_tag;
  logic [noc_pkg::BURST_WIDTH-1:0]   in_burst_length;
  logic [noc_pkg::ADDR_WIDTH-1:0]    in_address;
  noc_pkg::noc_status_e              in_header_status;
  logic                              in_payload_valid;
  logic                              in_payload_ready;
  logic [noc_pkg::DATA_WIDTH-1:0]    in_data;
  logic [noc_pkg::BE_WIDTH-1:0]      in_byte_enable;
  noc_pkg::noc_status_e              in_payload_status;
  logic                              in_payload_last;
  logic                              out_header_valid;
  logic                              out_header_ready;
  noc_pkg::noc_packet_type_e         out_packet_type;
  logic [noc_pkg::ID_WIDTH-1:0]      out_destination_id;
  logic [noc_pkg::ID_WIDTH-1:0]      out_source_id;
  logic [noc_pkg::TAG_WIDTH-1:0]     out_tag;
  logic [noc_pkg::BURST_WIDTH-1:0]   out_burst_length;
  logic [noc_pkg::ADDR_WIDTH-1:0]    out_address;
  noc_pkg::noc_status_e              out_header_status;
  logic                              out_payload_valid;
  logic                              out_payload_ready;
  logic [noc_pkg::DATA_WIDTH-1:0]    out_data;
  logic [noc_pkg::BE_WIDTH-1:0]      out_byte_enable;
  noc_pkg::noc_status_e              out_payload_status;
  logic                              out_payload_last;

  integer seed;
  int     errors;
  int     rx_packet;  // Progress of the receiver, for the timeout message
  int     rx_beat;

  // Packets as sent, indexed by packet number
  noc_pkg::noc_packet_type_e       pkt_type    [NUM_PACKETS];
  logic [noc_pkg::ID_WIDTH-1:0]    pkt_dest    [NUM_PACKETS];
  logic [noc_pkg::ID_WIDTH-1:0]    pkt_src     [NUM_PACKETS];
  logic [noc_pkg::TAG_WIDTH-1:0]   pkt_tag     [NUM_PACKETS];
  logic [noc_pkg::BURST_WIDTH-1:0] pkt_burst   [NUM_PACKETS];
  logic [noc_pkg::ADDR_WIDTH-1:0]  pkt_addr    [NUM_PACKETS];
  noc_pkg::noc_status_e            pkt_status  [NUM_PACKETS];
  logic [noc_pkg::DATA_WIDTH-1:0]  beat_data   [NUM_PACKETS][MAX_BEATS];
  logic [noc_pkg::BE_WIDTH-1:0]    beat_be     [NUM_PACKETS][MAX_BEATS];
  noc_pkg::noc_status_e            beat_status [NUM_PACKETS][MAX_BEATS];

  noc_endpoint_loopback UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .in_header_valid    (in_header_valid),
    .in_header_ready    (in_header_ready),
    .in_packet_type     (in_packet_type),
    .in_destination_id  (in_destination_id),
    .in_source_id       (in_source_id),
    .in_tag             (in_tag),
    .in_burst_length    (in_burst_length),
    .in_address         (in_address),
    .in_header_status   (in_header_status),
    .in_payload_valid   (in_payload_valid),
    .in_payload_ready   (in_payload_ready),
    .in_data            (in_data),
    .in_byte_enable     (in_byte_enable),
    .in_payload_status  (in_payload_status),
    .in_payload_last    (in_payload_last),
    .out_header_valid   (out_header_valid),
    .out_header_ready   (out_header_ready),
    .out_packet_type    (out_packet_type),
    .out_destination_id (out_destination_id),
    .out_source_id      (out_source_id),
    .out_tag            (out_tag),
    .out_burst_length   (out_burst_length),
    .out_address        (out_address),
    .out_header_status  (out_header_status),
    .out_payload_valid  (out_payload_valid),
    .out_payload_ready  (out_payload_ready),
    .out_data           (out_data),
    .out_byte_enable    (out_byte_enable),
    .out_payload_status (out_payload_status),
    .out_payload_last   (out_payload_last)
  );

  always #20 clk = ~clk;

  function automatic bit carries_payload(input noc_pkg::noc_packet_type_e kind);
    return (kind == noc_pkg::write_request) || (kind == noc_pkg::read_response);
  endfunction

  // Only requests have the second header word with the address
  function automatic bit carries_address(input noc_pkg::noc_packet_type_e kind);
    return (kind == noc_pkg::read_request) || (kind == noc_pkg::write_request);
  endfunction

  function automatic int beat_count(input int idx);
    return carries_payload(pkt_type[idx]) ? int'(pkt_burst[idx]) + 1 : 0;
  endfunction

  function automatic logic draw_ready(input bit stall);
    logic [31:0] draw;
    if (!stall) begin
      return 1'b1;
    end
    draw = $random(seed);
    return draw[0];
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_header(input int idx, input noc_pkg::noc_packet_type_e exp_type,
                              input logic [noc_pkg::ID_WIDTH-1:0] exp_dest,
                              input logic [noc_pkg::ID_WIDTH-1:0] exp_src,
                              input logic [noc_pkg::TAG_WIDTH-1:0] exp_tag,
                              input logic [noc_pkg::BURST_WIDTH-1:0] exp_burst,
                              input logic [noc_pkg::ADDR_WIDTH-1:0] exp_addr,
                              input noc_pkg::noc_status_e exp_status);
    if (out_packet_type !== exp_type)
      report_error($sformatf("packet %0d type expected %s got %s", idx, exp_type.name(),
                             out_packet_type.name()));
    if (out_destination_id !== exp_dest || out_source_id !== exp_src)
      report_error($sformatf("packet %0d ids expected %h/%h got %h/%h", idx, exp_dest, exp_src,
                             out_destination_id, out_source_id));
    if (out_tag !== exp_tag)
      report_error($sformatf("packet %0d tag expected %h got %h", idx, exp_tag, out_tag));
    if (out_burst_length !== exp_burst)
      report_error($sformatf("packet %0d burst expected %0d got %0d", idx, exp_burst,
                             out_burst_length));
    if (out_address !== exp_addr)
      report_error($sformatf("packet %0d address expected %h got %h", idx, exp_addr,
                             out_address));
    if (out_header_status !== exp_status)
      report_error($sformatf("packet %0d header status expected %s got %s", idx,
                             exp_status.name(), out_header_status.name()));
  endtask

  task automatic check_payload(input int idx, input int beat,
                               input logic [noc_pkg::DATA_WIDTH-1:0] exp_data,
                               input logic [noc_pkg::BE_WIDTH-1:0] exp_be,
                               input noc_pkg::noc_status_e exp_status, input logic exp_last);
    if (out_data !== exp_data || out_byte_enable !== exp_be)
      report_error($sformatf("packet %0d beat %0d data/be expected %h/%h got %h/%h", idx, beat,
                             exp_data, exp_be, out_data, out_byte_enable));
    if (out_payload_status !== exp_status)
      report_error($sformatf("packet %0d beat %0d status expected %s got %s", idx, beat,
                             exp_status.name(), out_payload_status.name()));
    if (out_payload_last !== exp_last)
      report_error($sformatf("packet %0d beat %0d last expected %b got %b", idx, beat,
                             exp_last, out_payload_last));
  endtask

  task automatic define_packet(input int idx, input noc_pkg::noc_packet_type_e kind,
                               input logic [3:0] dest, input logic [3:0] src,
                               input logic [3:0] tag, input logic [7:0] burst,
                               input logic [31:0] addr, input noc_pkg::noc_status_e status);
    logic [31:0] draw;
    pkt_type[idx]   = kind;
    pkt_dest[idx]   = dest;
    pkt_src[idx]    = src;
    pkt_tag[idx]    = tag;
    pkt_burst[idx]  = burst;
    pkt_addr[idx]   = addr;
    pkt_status[idx] = status;
    for (int b = 0; b < MAX_BEATS; b++) begin
      draw                = $random(seed);
      beat_be[idx][b]     = draw[3:0];
      beat_status[idx][b] = noc_pkg::noc_status_e'(draw[5:4]);
      beat_data[idx][b]   = $random(seed);
    end
  endtask

  task automatic define_random_packet(input int idx);
    logic [31:0]               draw;
    logic [31:0]               addr;
    noc_pkg::noc_packet_type_e kind;
    draw = $random(seed);
    addr = $random(seed);
    case (draw[1:0])
      2'd0:    kind = noc_pkg::write_request;
      2'd1:    kind = noc_pkg::read_request;
      2'd2:    kind = noc_pkg::read_response;
      default: kind = noc_pkg::write_response;
    endcase
    define_packet(idx, kind, draw[7:4], draw[11:8], draw[15:12], {5'd0, draw[18:16]}, addr,
                  noc_pkg::noc_status_e'(draw[21:20]));
  endtask

  task automatic send_packet(input int idx);
    int beats;
    beats = beat_count(idx);
    @(negedge clk);
    in_payload_valid  = 1'b0;
    in_payload_last   = 1'b0;
    in_header_valid   = 1'b1;
    in_packet_type    = pkt_type[idx];
    in_destination_id = pkt_dest[idx];
    in_source_id      = pkt_src[idx];
    in_tag            = pkt_tag[idx];
    in_burst_length   = pkt_burst[idx];
    in_address        = pkt_addr[idx];
    in_header_status  = pkt_status[idx];
    @(posedge clk);
    while (!in_header_ready) @(posedge clk);
    for (int b = 0; b < beats; b++) begin
      @(negedge clk);
      in_header_valid   = 1'b0;
      in_payload_valid  = 1'b1;
      in_data           = beat_data[idx][b];
      in_byte_enable    = beat_be[idx][b];
      in_payload_status = beat_status[idx][b];
      in_payload_last   = (b == beats - 1);
      @(posedge clk);
      while (!in_payload_ready) @(posedge clk);
    end
  endtask

  task automatic expect_packet(input int idx, input bit stall);
    int                             beats;
    logic                           taken;
    logic [noc_pkg::ADDR_WIDTH-1:0] exp_addr;
    logic [noc_pkg::BE_WIDTH-1:0]   exp_be;
    noc_pkg::noc_status_e           exp_status;
    beats     = beat_count(idx);
    rx_packet = idx;
    rx_beat   = -1;
    exp_addr  = carries_address(pkt_type[idx]) ? pkt_addr[idx] : '0;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk);
      out_payload_ready = 1'b0;
      out_header_ready  = draw_ready(stall);
      @(posedge clk);
      if (out_payload_valid)
        report_error($sformatf("payload beat seen before header of packet %0d", idx));
      taken = out_header_valid && out_header_ready;
    end
    check_header(idx, pkt_type[idx], pkt_dest[idx], pkt_src[idx], pkt_tag[idx], pkt_burst[idx],
                 exp_addr, pkt_status[idx]);
    for (int b = 0; b < beats; b++) begin
      rx_beat = b;
      taken   = 1'b0;
      while (!taken) begin
        @(negedge clk);
        out_header_ready  = 1'b0;
        out_payload_ready = draw_ready(stall);
        @(posedge clk);
        taken = out_payload_valid && out_payload_ready;
      end
      // Write payloads carry no status, read payloads carry no byte enables
      if (pkt_type[idx] == noc_pkg::write_request) begin
        exp_be     = beat_be[idx][b];
        exp_status = noc_pkg::okay;
      end else begin
        exp_be     = '0;
        exp_status = beat_status[idx][b];
      end
      check_payload(idx, b, beat_data[idx][b], exp_be, exp_status, b == beats - 1);
    end
  endtask

  task automatic check_idle(input int cycles);
    @(negedge clk);
    in_header_valid   = 1'b0;
    in_payload_valid  = 1'b0;
    out_header_ready  = 1'b0;
    out_payload_ready = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      if (out_header_valid || out_payload_valid)
        report_error("output valid raised with no packet in flight");
    end
  endtask

  task automatic run_packets(input int first, input int count, input bit stall);
    fork
      begin
        for (int i = first; i < first + count; i++) send_packet(i);
        @(negedge clk);
        in_header_valid  = 1'b0;  // Drop valid before the packer can see the header again
        in_payload_valid = 1'b0;
      end
      begin
        for (int j = first; j < first + count; j++) expect_packet(j, stall);
      end
    join
    check_idle(4);
  endtask

  task automatic test_idle_after_reset();
    check_idle(8);
  endtask

  task automatic test_write_request();
    define_packet(0, noc_pkg::write_request, 4'h3, 4'h1, 4'h5, 8'd3, 32'h1000_0040,
                  noc_pkg::okay);
    run_packets(0, 1, 1'b1);
  endtask

  task automatic test_read_request();
    define_packet(1, noc_pkg::read_request, 4'h7, 4'h2, 4'ha, 8'd0, 32'h2000_0100,
                  noc_pkg::okay);
    run_packets(1, 1, 1'b0);
  endtask

  task automatic test_read_response();
    define_packet(2, noc_pkg::read_response, 4'h1, 4'h3, 4'h5, 8'd2, 32'hdead_beef,
                  noc_pkg::exokay);
    run_packets(2, 1, 1'b0);
  endtask

  task automatic test_write_response();
    define_packet(3, noc_pkg::write_response, 4'h1, 4'h3, 4'h6, 8'd0, 32'h0000_1234,
                  noc_pkg::slverr);
    run_packets(3, 1, 1'b0);
  endtask

  task automatic test_mixed_stream();
    for (int i = 4; i < NUM_PACKETS; i++) define_random_packet(i);
    run_packets(4, NUM_PACKETS - 4, 1'b1);
  endtask

  // Ends a run that stops making progress
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    if (rx_beat < 0)
      $display("Timeout: the header of packet %0d never reached the output", rx_packet);
    else
      $display("Timeout: beat %0d of packet %0d never reached the output", rx_beat, rx_packet);
    $display("Run ended with %0d errors", errors);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed              = 32'h7244;
    errors            = 0;
    rx_packet         = 0;
    rx_beat           = -1;
    clk               = 1'b0;
    rst_n             = 1'b0;
    in_header_valid   = 1'b0;
    in_packet_type    = noc_pkg::read_request;
    in_destination_id = '0;
    in_source_id      = '0;
    in_tag            = '0;
    in_burst_length   = '0;
    in_address        = '0;
    in_header_status  = noc_pkg::okay;
    in_payload_valid  = 1'b0;
    in_data           = '0;
    in_byte_enable    = '0;
    in_payload_status = noc_pkg::okay;
    in_payload_last   = 1'b0;
    out_header_ready  = 1'b0;
    out_payload_ready = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_idle_after_reset();
    test_write_request();
    test_read_request();
    test_read_response();
    test_write_response();
    test_mixed_stream();
    $display("Run ended with %0d errors", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
